//--- logic/dcache_array.sv
// direct-mapped cache storage
`timescale 1ns/10ps
`default_nettype none

module dcache_array (
  input  wire                      clock,
  input  wire                      reset,
  input  dcache_pkg::cache_addr_t  rd_addr,
  output logic [63:0]              rd_data,
  output logic                     rd_hit,
  input  dcache_pkg::cache_wr_t    fill_wr,
  input  dcache_pkg::cache_wr_t    store_wr
);

  import dcache_pkg::*;

  logic [CACHE_LINES-1:0] line_valid;
  logic [TAG_BITS-1:0]    line_tag  [CACHE_LINES];
  logic [DATA_BITS-1:0]   line_data [CACHE_LINES];

  // asynchronous lookup
  assign rd_data = line_data[rd_addr.idx];
  assign rd_hit  = line_valid[rd_addr.idx] && (line_tag[rd_addr.idx] == rd_addr.tag);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      line_valid <= '0;
    end
    else
    begin
      if (fill_wr.en)
      begin
        line_valid[fill_wr.idx] <= 1'b1;
      end
      if (store_wr.en)
      begin
        line_valid[store_wr.idx] <= 1'b1;
      end
    end
  end

  // store written last so it wins on an index clash
  always_ff @(posedge clock)
  begin
    if (fill_wr.en)
    begin
      line_tag[fill_wr.idx]  <= fill_wr.tag;
      line_data[fill_wr.idx] <= fill_wr.data;
    end
    if (store_wr.en)
    begin
      line_tag[store_wr.idx]  <= store_wr.tag;
      line_data[store_wr.idx] <= store_wr.data;
    end
  end

endmodule

`default_nettype wire

//--- logic/dcache_cmd_queue.sv
// memory command queue
`timescale 1ns/10ps
`default_nettype none

module dcache_cmd_queue (
  input  wire                     clock,
  input  wire                     reset,
  input  wire                     push,
  input  dcache_pkg::cmd_entry_t  push_entry,
  input  wire                     pop,
  output dcache_pkg::cmd_entry_t  head,
  output logic                    empty
);

  import dcache_pkg::*;

  cmd_entry_t           entries [QUEUE_DEPTH];
  logic [QPTR_BITS-1:0] head_ptr;
  logic [QPTR_BITS-1:0] tail_ptr;
  logic [QPTR_BITS:0]   count;               // one extra bit so full fits
  logic [QPTR_BITS-1:0] head_next;
  logic [QPTR_BITS-1:0] tail_next;

  // pointers wrap at the last entry
  assign head_next = (head_ptr == QPTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : head_ptr + 1'b1;
  assign tail_next = (tail_ptr == QPTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : tail_ptr + 1'b1;

  assign head  = entries[head_ptr];
  assign empty = (count == '0);

  // payload storage
  always_ff @(posedge clock)
  begin
    if (push)
    begin
      entries[tail_ptr] <= push_entry;
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end
    else
    begin
      if (push)
      begin
        tail_ptr <= tail_next;
      end
      if (pop)
      begin
        head_ptr <= head_next;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;           // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/dcache_ctrl.sv
// data cache controller
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl (
  input  wire                      clock,
  input  wire                      reset,
  input  dcache_pkg::lsq_req_t     lsq_req,
  input  dcache_pkg::store_req_t   store_req,
  input  wire                      halt_req,
  input  wire                      rd_hit,
  input  wire [63:0]               rd_data,
  output dcache_pkg::cache_addr_t  rd_addr,
  output dcache_pkg::cache_wr_t    fill_wr,
  output dcache_pkg::cache_wr_t    store_wr,
  output logic                     push,
  output dcache_pkg::cmd_entry_t   push_entry,
  output logic                     pop,
  input  dcache_pkg::cmd_entry_t   head,
  input  wire                      empty,
  input  dcache_pkg::mem_resp_t    mem_resp,
  output dcache_pkg::mem_req_t     mem_req,
  output dcache_pkg::cdb_t         cdb,
  output logic                     load_avail,
  output logic                     halted
);

  import dcache_pkg::*;

  // outstanding load table indexed by memory tag
  logic [MEM_TAGS-1:0] occupied;
  logic [IDX_BITS-1:0] tbl_idx [MEM_TAGS];
  logic [TAG_BITS-1:0] tbl_tag [MEM_TAGS];
  logic [PR_BITS-1:0]  tbl_pr  [MEM_TAGS];
  logic [AR_BITS-1:0]  tbl_ar  [MEM_TAGS];

  logic load_hit;
  logic load_miss;
  logic accept;
  logic accept_load;
  logic fill_done;
  logic halt_latched;
  logic drained;

  assign rd_addr   = lsq_req.addr;
  assign load_hit  = lsq_req.valid && rd_hit;
  assign load_miss = lsq_req.valid && !rd_hit;

  // memory takes the head when it hands back a free tag
  assign accept      = !empty && (mem_resp.response != '0) && !occupied[mem_resp.response];
  assign accept_load = accept && (head.cmd == MEM_LOAD);
  assign fill_done   = (mem_resp.tag != '0) && occupied[mem_resp.tag];

  assign load_avail = !store_req.valid && !fill_done;

  assign mem_req = '{cmd: (empty ? MEM_NONE : head.cmd), addr: head.addr, data: head.data};

  assign push = store_req.valid || load_miss;
  assign pop  = accept;

  // store has priority for the single push slot
  always_comb
  begin
    push_entry = '0;
    if (store_req.valid)
    begin
      push_entry.cmd  = MEM_STORE;
      push_entry.addr = store_req.addr;
      push_entry.data = store_req.data;
    end
    else
    begin
      push_entry.cmd  = MEM_LOAD;
      push_entry.addr = lsq_req.addr;
      push_entry.pr   = lsq_req.pr;
      push_entry.ar   = lsq_req.ar;
    end
  end

  // write-through store goes straight into the array
  assign store_wr = '{en: store_req.valid, idx: store_req.addr.idx,
                      tag: store_req.addr.tag, data: store_req.data};

  assign fill_wr = '{en: fill_done, idx: tbl_idx[mem_resp.tag],
                     tag: tbl_tag[mem_resp.tag], data: mem_resp.data};

  // fill return takes the bus and holds off the lsq that cycle
  always_comb
  begin
    cdb = '0;
    if (fill_done)
    begin
      cdb.valid = 1'b1;
      cdb.pr    = tbl_pr[mem_resp.tag];
      cdb.ar    = tbl_ar[mem_resp.tag];
      cdb.data  = mem_resp.data;
    end
    else if (load_hit)
    begin
      cdb.valid = 1'b1;
      cdb.pr    = lsq_req.pr;
      cdb.ar    = lsq_req.ar;
      cdb.data  = rd_data;
    end
  end

  always_ff @(posedge clock)
  begin
    if (accept_load)
    begin
      tbl_idx[mem_resp.response] <= head.addr.idx;
      tbl_tag[mem_resp.response] <= head.addr.tag;
      tbl_pr[mem_resp.response]  <= head.pr;
      tbl_ar[mem_resp.response]  <= head.ar;
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      occupied <= '0;
    end
    else
    begin
      if (fill_done)
      begin
        occupied[mem_resp.tag] <= 1'b0;
      end
      if (accept_load)
      begin
        occupied[mem_resp.response] <= 1'b1;   // stores never hold a slot
      end
    end
  end

  // nothing queued, nothing in flight, nothing arriving
  assign drained = halt_latched && empty && !push && (occupied == '0);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      halt_latched <= 1'b0;
      halted       <= 1'b0;
    end
    else
    begin
      halt_latched <= halt_latched || halt_req;
      halted       <= halted || drained;       // sticky until reset
    end
  end

endmodule

`default_nettype wire

//--- logic/dcache_pkg.sv
// data cache shared types
`default_nettype none

package dcache_pkg;

  localparam int ADDR_BITS   = 32;
  localparam int TAG_BITS    = 22;           // addr[31:10]
  localparam int IDX_BITS    = 7;            // addr[9:3]
  localparam int OFF_BITS    = ADDR_BITS - TAG_BITS - IDX_BITS;
  localparam int DATA_BITS   = 64;
  localparam int CACHE_LINES = 128;
  localparam int QUEUE_DEPTH = 16;
  localparam int QPTR_BITS   = $clog2(QUEUE_DEPTH);
  localparam int MEM_TAGS    = 16;           // tag 0 is reserved for none
  localparam int MTAG_BITS   = $clog2(MEM_TAGS);
  localparam int PR_BITS     = 7;
  localparam int AR_BITS     = 5;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_cmd_e;

  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
    logic [IDX_BITS-1:0] idx;
    logic [OFF_BITS-1:0] offset;             // always zero for 8-byte alignment
  } cache_addr_t;

  // load request from the lsq
  typedef struct packed {
    logic               valid;
    logic [PR_BITS-1:0] pr;
    logic [AR_BITS-1:0] ar;
    cache_addr_t        addr;
  } lsq_req_t;

  // retiring store from the rob
  typedef struct packed {
    logic                 valid;
    cache_addr_t          addr;
    logic [DATA_BITS-1:0] data;
  } store_req_t;

  typedef struct packed {
    logic                 valid;
    logic [PR_BITS-1:0]   pr;
    logic [AR_BITS-1:0]   ar;
    logic [DATA_BITS-1:0] data;
  } cdb_t;

  typedef struct packed {
    mem_cmd_e             cmd;
    cache_addr_t          addr;
    logic [DATA_BITS-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic [MTAG_BITS-1:0] response;          // acceptance tag or zero when not taken
    logic [MTAG_BITS-1:0] tag;               // data return tag
    logic [DATA_BITS-1:0] data;
  } mem_resp_t;

  typedef struct packed {
    mem_cmd_e             cmd;
    cache_addr_t          addr;
    logic [DATA_BITS-1:0] data;
    logic [PR_BITS-1:0]   pr;
    logic [AR_BITS-1:0]   ar;
  } cmd_entry_t;

  typedef struct packed {
    logic                 en;
    logic [IDX_BITS-1:0]  idx;
    logic [TAG_BITS-1:0]  tag;
    logic [DATA_BITS-1:0] data;
  } cache_wr_t;

endpackage

`default_nettype wire

//--- logic/dcache_top.sv
// data cache subsystem top
`timescale 1ns/10ps
`default_nettype none

module dcache_top (
  input  wire                     clock,
  input  wire                     reset,
  input  dcache_pkg::lsq_req_t    lsq_req,
  input  dcache_pkg::store_req_t  store_req,
  input  wire                     halt_req,
  input  dcache_pkg::mem_resp_t   mem_resp,
  output dcache_pkg::cdb_t        cdb,
  output dcache_pkg::mem_req_t    mem_req,
  output logic                    load_avail,
  output logic                    halted
);

  import dcache_pkg::*;

  cache_addr_t          rd_addr;
  logic [DATA_BITS-1:0] rd_data;
  logic                 rd_hit;
  cache_wr_t            fill_wr;
  cache_wr_t            store_wr;
  logic                 push;
  cmd_entry_t           push_entry;
  logic                 pop;
  cmd_entry_t           head;
  logic                 empty;

  dcache_ctrl dcache_ctrl_i (
    .clock      (clock),
    .reset      (reset),
    .lsq_req    (lsq_req),
    .store_req  (store_req),
    .halt_req   (halt_req),
    .rd_hit     (rd_hit),
    .rd_data    (rd_data),
    .rd_addr    (rd_addr),
    .fill_wr    (fill_wr),
    .store_wr   (store_wr),
    .push       (push),
    .push_entry (push_entry),
    .pop        (pop),
    .head       (head),
    .empty      (empty),
    .mem_resp   (mem_resp),
    .mem_req    (mem_req),
    .cdb        (cdb),
    .load_avail (load_avail),
    .halted     (halted)
  );

  dcache_cmd_queue dcache_cmd_queue_i (
    .clock      (clock),
    .reset      (reset),
    .push       (push),
    .push_entry (push_entry),
    .pop        (pop),
    .head       (head),
    .empty      (empty)
  );

  dcache_array dcache_array_i (
    .clock    (clock),
    .reset    (reset),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rd_hit   (rd_hit),
    .fill_wr  (fill_wr),
    .store_wr (store_wr)
  );

endmodule

`default_nettype wire

//--- src.f
logic/dcache_pkg.sv
logic/dcache_cmd_queue.sv
logic/dcache_array.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

//--- verification/dcache_mem_model.sv
// tagged memory model
`timescale 1ns/10ps
`default_nettype none

module dcache_mem_model (
  input  wire                    clock,
  input  wire                    reset,
  input  dcache_pkg::mem_req_t   mem_req,
  output dcache_pkg::mem_resp_t  mem_resp,
  output logic                   return_next
);

  import dcache_pkg::*;

  logic [DATA_BITS-1:0] words [logic [ADDR_BITS-1:0]];
  logic [MEM_TAGS-1:0]  pending;               // loads waiting for their data
  int                   wait_cycles [MEM_TAGS];
  logic [DATA_BITS-1:0] load_data   [MEM_TAGS];
  logic [MTAG_BITS-1:0] ret_tag;
  logic [DATA_BITS-1:0] ret_data;
  logic [MTAG_BITS-1:0] free_tag;
  logic [MTAG_BITS-1:0] due_tag;

  // untouched words read back a pattern of their own address
  function automatic logic [DATA_BITS-1:0] read_word(input logic [ADDR_BITS-1:0] addr);
    if (words.exists(addr))
      return words[addr];
    return {addr ^ 32'h5a5a_a5a5, ~addr};
  endfunction

  // lowest free and lowest due tag above tag 0
  always_comb
  begin
    free_tag = '0;
    due_tag  = '0;
    for (int t = MEM_TAGS - 1; t > 0; t--)
    begin
      if (!pending[t] && ret_tag != MTAG_BITS'(t))
        free_tag = MTAG_BITS'(t);
      if (pending[t] && wait_cycles[t] == 0)
        due_tag = MTAG_BITS'(t);
    end
  end

  assign mem_resp = '{response: (mem_req.cmd != MEM_NONE) ? free_tag : '0,
                      tag: ret_tag, data: ret_data};
  assign return_next = (due_tag != '0);    // data tag shows up next cycle

  always @(posedge clock)
  begin
    if (reset)
    begin
      pending  <= '0;
      ret_tag  <= '0;
      ret_data <= '0;
    end
    else
    begin
      for (int t = 1; t < MEM_TAGS; t++)
      begin
        if (pending[t] && wait_cycles[t] > 0)
          wait_cycles[t] <= wait_cycles[t] - 1;
      end
      ret_tag  <= due_tag;
      ret_data <= load_data[due_tag];
      if (due_tag != '0)
        pending[due_tag] <= 1'b0;
      if (mem_resp.response != '0)
      begin
        if (mem_req.cmd == MEM_STORE)
          words[mem_req.addr] = mem_req.data;  // applied on acceptance
        else
        begin
          pending[mem_resp.response]     <= 1'b1;
          wait_cycles[mem_resp.response] <= int'($urandom_range(9, 2)) - 1;
          load_data[mem_resp.response]   <= read_word(mem_req.addr);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/dcache_tb.sv
// data cache subsystem testbench
`timescale 1ns/10ps
`default_nettype none

module dcache_tb;

  import dcache_pkg::*;

  localparam int NUM_OPS      = 300;
  localparam int MAX_INFLIGHT = 12;            // kept below the queue depth
  localparam int CLK_PERIOD   = 20;

  logic       clock;
  logic       reset;
  lsq_req_t   lsq_req;
  store_req_t store_req;
  logic       halt_req;
  mem_resp_t  mem_resp;
  cdb_t       cdb;
  mem_req_t   mem_req;
  logic       load_avail;
  logic       halted;
  logic       return_next;

  // reference model
  logic [DATA_BITS-1:0] image [logic [ADDR_BITS-1:0]];
  logic                 line_valid [CACHE_LINES];
  logic [TAG_BITS-1:0]  line_tag   [CACHE_LINES];
  logic [DATA_BITS-1:0] line_data  [CACHE_LINES];
  cmd_entry_t           cmd_q [$];             // expected order on mem_req
  cmd_entry_t           in_flight    [MEM_TAGS];
  logic                 flight_valid [MEM_TAGS];
  logic                 miss_open [1 << PR_BITS];
  cache_addr_t          miss_addr [1 << PR_BITS];

  int                 checks;
  int                 mismatches;
  int                 errors;
  int                 ops_issued;
  int                 rand_init;
  logic               halt_seen;
  logic               halted_exp;
  logic [PR_BITS-1:0] next_pr;
  lsq_req_t           next_lsq;
  store_req_t         next_store;

  dcache_top dcache_top_i (
    .clock      (clock),
    .reset      (reset),
    .lsq_req    (lsq_req),
    .store_req  (store_req),
    .halt_req   (halt_req),
    .mem_resp   (mem_resp),
    .cdb        (cdb),
    .mem_req    (mem_req),
    .load_avail (load_avail),
    .halted     (halted)
  );

  dcache_mem_model mem_model_i (
    .clock       (clock),
    .reset       (reset),
    .mem_req     (mem_req),
    .mem_resp    (mem_resp),
    .return_next (return_next)
  );

  initial clock = 1'b0;
  always #(CLK_PERIOD / 2) clock = ~clock;

  function automatic logic [DATA_BITS-1:0] image_read(input cache_addr_t addr);
    if (image.exists(addr))
      return image[addr];
    return {addr ^ 32'h5a5a_a5a5, ~addr};  // memory fill pattern
  endfunction

  function automatic int flight_count();
    int n;
    n = 0;
    for (int t = 0; t < MEM_TAGS; t++)
      n += flight_valid[t];
    return n;
  endfunction

  // two tags over four indexes make conflicts common
  function automatic cache_addr_t pick_addr();
    cache_addr_t a;
    a.tag    = ($urandom % 2) ? TAG_BITS'(22'h2ab3) : TAG_BITS'(22'h1);
    a.idx    = IDX_BITS'(($urandom % 4) * 37);
    a.offset = '0;
    return a;
  endfunction

  function automatic logic store_blocked(input cache_addr_t addr);
    for (int p = 0; p < (1 << PR_BITS); p++)
    begin
      if (miss_open[p] && miss_addr[p] == addr)
        return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic compare_cdb(input cdb_t got, input cdb_t exp);
    checks++;
    if (got.valid !== exp.valid || (exp.valid &&
        (got.pr !== exp.pr || got.ar !== exp.ar || got.data !== exp.data)))
    begin
      mismatches++;
      $display("Mismatch at %0t: cdb %0b/%0d/%0d/%h, expected %0b/%0d/%0d/%h", $time,
               got.valid, got.pr, got.ar, got.data, exp.valid, exp.pr, exp.ar, exp.data);
    end
  endtask

  task automatic compare_mem_req(input mem_req_t got, input mem_req_t exp);
    checks++;
    if (got.cmd !== exp.cmd || (exp.cmd != MEM_NONE && got.addr !== exp.addr) ||
        (exp.cmd == MEM_STORE && got.data !== exp.data))
    begin
      mismatches++;
      $display("Mismatch at %0t: mem_req %s %h %h, expected %s %h %h", $time,
               got.cmd.name(), got.addr, got.data, exp.cmd.name(), exp.addr, exp.data);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      mismatches++;
      $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // one reference model cycle sampled at the falling edge
  task automatic check_cycle();
    cdb_t                 exp_cdb;
    mem_req_t             exp_req;
    cmd_entry_t           entry;
    logic                 hit;
    logic                 fill;
    logic                 drained;
    logic [MTAG_BITS-1:0] t;
    hit = lsq_req.valid && line_valid[lsq_req.addr.idx] &&
          line_tag[lsq_req.addr.idx] == lsq_req.addr.tag;
    drained = halt_seen && cmd_q.size() == 0 && flight_count() == 0 &&
              !store_req.valid && !(lsq_req.valid && !hit);
    compare_flag("halted", halted, halted_exp);
    exp_req = '{cmd: MEM_NONE, addr: '0, data: '0};
    if (cmd_q.size() > 0)
      exp_req = '{cmd: cmd_q[0].cmd, addr: cmd_q[0].addr, data: cmd_q[0].data};
    compare_mem_req(mem_req, exp_req);
    fill    = (mem_resp.tag != '0);
    exp_cdb = '0;
    if (fill)
    begin
      t = mem_resp.tag;
      if (!flight_valid[t])
      begin
        errors++;
        $display("Error at %0t: memory returned tag %0d with no load in flight", $time, t);
      end
      else
      begin
        entry           = in_flight[t];
        flight_valid[t] = 1'b0;
        exp_cdb = '{valid: 1'b1, pr: entry.pr, ar: entry.ar, data: entry.data};
        if (!miss_open[entry.pr])
        begin
          errors++;
          $display("Error at %0t: load pr %0d was broadcast twice", $time, entry.pr);
        end
        miss_open[entry.pr]            = 1'b0;
        line_valid[entry.addr.idx]     = 1'b1;
        line_tag[entry.addr.idx]       = entry.addr.tag;
        line_data[entry.addr.idx]      = entry.data;
      end
    end
    else if (hit)
      exp_cdb = '{valid: 1'b1, pr: lsq_req.pr, ar: lsq_req.ar,
                  data: line_data[lsq_req.addr.idx]};
    compare_cdb(cdb, exp_cdb);
    compare_flag("load_avail", load_avail, !store_req.valid && !fill);
    if (mem_resp.response != '0 && cmd_q.size() > 0)
    begin
      entry = cmd_q.pop_front();
      if (entry.cmd == MEM_LOAD)
      begin
        in_flight[mem_resp.response]    = entry;
        flight_valid[mem_resp.response] = 1'b1;
      end
    end
    if (store_req.valid)
    begin
      image[store_req.addr]          = store_req.data;
      line_valid[store_req.addr.idx] = 1'b1;   // store is newer than the fill
      line_tag[store_req.addr.idx]   = store_req.addr.tag;
      line_data[store_req.addr.idx]  = store_req.data;
      cmd_q.push_back('{cmd: MEM_STORE, addr: store_req.addr, data: store_req.data,
                        pr: '0, ar: '0});
    end
    else if (lsq_req.valid && !hit)
    begin
      cmd_q.push_back('{cmd: MEM_LOAD, addr: lsq_req.addr, data: image_read(lsq_req.addr),
                        pr: lsq_req.pr, ar: lsq_req.ar});
      miss_open[lsq_req.pr] = 1'b1;
      miss_addr[lsq_req.pr] = lsq_req.addr;
    end
    halted_exp = halted_exp || drained;
    if (halt_req)
      halt_seen = 1'b1;
  endtask

  task automatic plan_stimulus(output lsq_req_t l, output store_req_t s);
    int          r;
    cache_addr_t a;
    l = '0;
    s = '0;
    if (ops_issued >= NUM_OPS || cmd_q.size() + flight_count() >= MAX_INFLIGHT)
      return;
    r = $urandom % 10;
    a = pick_addr();
    if (r < 4 && !return_next)                 // a fill would take the bus
    begin
      while (miss_open[next_pr])
        next_pr++;
      l = '{valid: 1'b1, pr: next_pr, ar: AR_BITS'($urandom), addr: a};
      next_pr++;
      ops_issued++;
    end
    else if (r >= 4 && r < 7 && !store_blocked(a))
    begin
      s = '{valid: 1'b1, addr: a, data: {$urandom, $urandom}};
      ops_issued++;
    end
  endtask

  initial
  begin
    rand_init  = $urandom(74728);
    lsq_req    = '0;
    store_req  = '0;
    halt_req   = 1'b0;
    reset      = 1'b1;
    checks     = 0;
    mismatches = 0;
    errors     = 0;
    ops_issued = 0;
    halt_seen  = 1'b0;
    halted_exp = 1'b0;
    next_pr    = '0;
    for (int i = 0; i < CACHE_LINES; i++)
      line_valid[i] = 1'b0;
    for (int i = 0; i < MEM_TAGS; i++)
      flight_valid[i] = 1'b0;
    for (int i = 0; i < (1 << PR_BITS); i++)
      miss_open[i] = 1'b0;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    repeat (3)
    begin
      @(negedge clock);
      check_cycle();                           // idle outputs after reset
    end
    while (ops_issued < NUM_OPS)
    begin
      @(negedge clock);
      check_cycle();
      plan_stimulus(next_lsq, next_store);
      @(posedge clock);
      lsq_req   <= next_lsq;
      store_req <= next_store;
    end
    @(negedge clock);
    check_cycle();
    while (return_next)                        // wait until no fill is due
    begin
      @(posedge clock);
      lsq_req   <= '0;
      store_req <= '0;
      @(negedge clock);
      check_cycle();
    end
    while (miss_open[next_pr])
      next_pr++;
    // tag 3 lies outside the address pool and always misses
    @(posedge clock);
    lsq_req   <= '{valid: 1'b1, pr: next_pr, ar: '0,
                   addr: '{tag: TAG_BITS'(3), idx: '0, offset: '0}};
    store_req <= '0;
    @(negedge clock);
    check_cycle();
    @(posedge clock);
    lsq_req   <= '0;
    store_req <= '0;
    halt_req  <= 1'b1;
    while (halted !== 1'b1 && !halted_exp)
    begin
      @(negedge clock);
      check_cycle();
    end
    @(negedge clock);
    check_cycle();
    for (int p = 0; p < (1 << PR_BITS); p++)
    begin
      if (miss_open[p])
      begin
        errors++;
        $display("Error: load with pr %0d was never broadcast", p);
      end
    end
    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, errors);
    if (mismatches == 0 && errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // run limit scales with the number of operations
  initial
  begin
    #((NUM_OPS * 40 + 16) * CLK_PERIOD);
    $display("Error: watchdog expired before the run completed");
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire
